// File: verilog.f
+incdir+src
src/conv_pkg.sv
src/spad_bus_if.sv
src/scratchpad.sv
src/tile_loader.sv
src/array_feeder.sv
src/systolic_array.sv
src/ofmap_drain.sv
src/conv_top.sv
sim/conv_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing -Wno-fatal -j 0
TOP      = conv_tb
FILELIST = verilog.f

.PHONY: sim clean

# the run passes only if the pass line shows up in the output
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf obj_dir

// File: sim/conv_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "conv_defines.svh"

module conv_tb;
  import conv_pkg::*;

  localparam int DIM = `CONV_ARRAY_DIM;
  localparam int NIF = `CONV_PIXELS * `CONV_ARRAY_DIM;  // ifmap words per job
  localparam int NWT = DIM * DIM;
  localparam int WORD_TIMEOUT = 3000;  // cycles per input word
  localparam int DRAIN_TIMEOUT = 5000;

  logic clk;
  logic rst_n;
  ifmap_word_t ifmap_dat;
  logic ifmap_vld;
  logic ifmap_rdy;
  weight_word_t weights_dat;
  logic weights_vld;
  logic weights_rdy;
  ofmap_word_t ofmap_dat;
  logic ofmap_vld;
  logic ofmap_rdy;

  logic [31:0] rng_state;
  logic [31:0] rdy_rand;
  logic bp_on;
  int error_count;
  int tests_run;
  int tests_failed;
  ifmap_word_t ifm_mem [NIF];
  weight_word_t wts_mem [NWT];
  ofmap_word_t exp_q [$];
  ofmap_word_t got_q [$];

  conv_top dut0 (
    .clk(clk), .rst_n(rst_n),
    .ifmap_dat(ifmap_dat), .ifmap_vld(ifmap_vld), .ifmap_rdy(ifmap_rdy),
    .weights_dat(weights_dat), .weights_vld(weights_vld), .weights_rdy(weights_rdy),
    .ofmap_dat(ofmap_dat), .ofmap_vld(ofmap_vld), .ofmap_rdy(ofmap_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic logic stream_rdy(input int sel);
    return (sel == 0) ? ifmap_rdy : weights_rdy;
  endfunction

  // output consumer with random rdy under back-pressure
  always @(posedge clk) begin
    #2;
    rdy_rand = next_rand();
    ofmap_rdy = bp_on ? rdy_rand[7] : 1'b1;
  end

  // sample at the falling edge where nothing moves
  always @(negedge clk) begin
    if (rst_n && ofmap_vld && ofmap_rdy) got_q.push_back(ofmap_dat);
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("** Error %s: expected %h, actual %h", name, expected, actual);
      error_count++;
    end
  endtask

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("FAIL: see errors above");
    $finish;
  endtask

  task automatic finish_test(input string name, input int errs_before);
    tests_run++;
    if (error_count == errs_before) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, error_count - errs_before);
    end
  endtask

  // new random tile pair plus the expected ofmap words
  task automatic make_job();
    ofmap_word_t acc;
    int p;
    int oc;
    int ic;
    for (p = 0; p < NIF; p++) ifm_mem[p] = ifmap_word_t'(next_rand());
    for (p = 0; p < NWT; p++) wts_mem[p] = weight_word_t'(next_rand());
    for (p = 0; p < `CONV_PIXELS; p++) begin
      for (oc = 0; oc < DIM; oc++) begin
        acc = '0;
        for (ic = 0; ic < DIM; ic++) begin
          acc = acc + ofmap_word_t'(ifm_mem[p*DIM + ic]) * ofmap_word_t'(wts_mem[ic*DIM + oc]);
        end
        exp_q.push_back(acc);
      end
    end
  endtask

  // runs from 2 ns past an edge to 2 ns past the transfer edge
  task automatic send_word(input int sel, input logic [15:0] d, input int gap_max);
    int gap;
    int waited;
    gap = (gap_max > 0) ? int'(next_rand() % 32'(gap_max + 1)) : 0;
    repeat (gap) begin
      @(posedge clk);
      #2;
    end
    if (sel == 0) begin
      ifmap_dat = d;
      ifmap_vld = 1'b1;
    end else begin
      weights_dat = d;
      weights_vld = 1'b1;
    end
    waited = 0;
    while (!stream_rdy(sel) && waited < WORD_TIMEOUT) begin
      @(posedge clk);
      #2;
      waited++;
    end
    if (!stream_rdy(sel)) begin
      abort_run($sformatf("timeout: %s stream never became ready",
                          (sel == 0) ? "ifmap" : "weights"));
    end else begin
      @(posedge clk);
      #2;
      if (sel == 0) ifmap_vld = 1'b0;
      else weights_vld = 1'b0;
    end
  endtask

  task automatic send_ifmap(input int gap_max);
    int k;
    for (k = 0; k < NIF; k++) send_word(0, ifm_mem[k], gap_max);
  endtask

  task automatic send_weights(input int gap_max);
    int k;
    for (k = 0; k < NWT; k++) send_word(1, wts_mem[k], gap_max);
  endtask

  task automatic send_job(input logic ifmap_first, input int gap_max);
    if (ifmap_first) begin
      send_ifmap(gap_max);
      send_weights(gap_max);
    end else begin
      fork
        send_ifmap(gap_max);
        send_weights(gap_max);
      join
    end
  endtask

  task automatic collect(input string name, input int n);
    int waited;
    int k;
    ofmap_word_t exp_w;
    ofmap_word_t act_w;
    waited = 0;
    while (got_q.size() < n && waited < DRAIN_TIMEOUT) begin
      @(posedge clk);
      #2;
      waited++;
    end
    if (got_q.size() < n) begin
      abort_run($sformatf("timeout: %s got only %0d of %0d ofmap words",
                          name, got_q.size(), n));
    end else begin
      for (k = 0; k < n; k++) begin
        exp_w = exp_q.pop_front();
        act_w = got_q.pop_front();
        check_value($sformatf("%s word %0d", name, k), exp_w, act_w);
      end
    end
  endtask

  // nothing more may show up once a test is drained
  task automatic check_idle(input string name);
    repeat (40) begin
      @(posedge clk);
      #2;
    end
    check_value({name, " extra ofmap words"}, 32'd0, 32'(got_q.size()));
    got_q.delete();
  endtask

  initial begin
    int errs;
    int bad;
    int j;
    rng_state = 32'd31;
    rdy_rand = '0;
    bp_on = 1'b0;
    error_count = 0;
    tests_run = 0;
    tests_failed = 0;
    rst_n = 1'b0;
    ifmap_dat = '0;
    ifmap_vld = 1'b0;
    weights_dat = '0;
    weights_vld = 1'b0;
    ofmap_rdy = 1'b1;
    repeat (10) @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(posedge clk);
    #2;

    errs = error_count;
    make_job();
    send_job(1'b0, 0);
    collect("single_job", NIF);
    check_idle("single_job");
    finish_test("single_job", errs);

    errs = error_count;
    bp_on = 1'b1;
    make_job();
    send_job(1'b0, 0);
    collect("backpressure", NIF);
    check_idle("backpressure");
    bp_on = 1'b0;
    finish_test("backpressure", errs);

    errs = error_count;
    make_job();
    send_job(1'b1, 4);
    collect("interleaved_arrival", NIF);
    check_idle("interleaved_arrival");
    finish_test("interleaved_arrival", errs);

    errs = error_count;
    make_job();
    send_ifmap(0);
    bad = 0;
    repeat (50) begin  // job must not start without weights
      @(posedge clk);
      #2;
      if (ifmap_rdy || !weights_rdy || ofmap_vld) bad++;
    end
    check_value("tile_full_hold busy cycles", 32'd0, 32'(bad));
    send_weights(0);
    collect("tile_full_hold", NIF);
    check_idle("tile_full_hold");
    finish_test("tile_full_hold", errs);

    errs = error_count;
    bp_on = 1'b1;
    for (j = 0; j < 3; j++) begin
      make_job();
      send_job(1'b0, 3);
    end
    for (j = 0; j < 3; j++) collect($sformatf("back_to_back_jobs job %0d", j), NIF);
    check_idle("back_to_back_jobs");
    bp_on = 1'b0;
    finish_test("back_to_back_jobs", errs);

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
    if (error_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src/conv_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "conv_defines.svh"

module conv_top (
  input logic clk,
  input logic rst_n,
  input conv_pkg::ifmap_word_t ifmap_dat,
  input logic ifmap_vld,
  output logic ifmap_rdy,
  input conv_pkg::weight_word_t weights_dat,
  input logic weights_vld,
  output logic weights_rdy,
  output conv_pkg::ofmap_word_t ofmap_dat,
  output logic ofmap_vld,
  input logic ofmap_rdy
);
  import conv_pkg::*;

  localparam int DIM = `CONV_ARRAY_DIM;

  logic weights_full;
  logic ifmap_full;
  logic tile_release;
  logic weight_load;
  weight_word_t weight_row [DIM];
  logic row_vld;
  ifmap_word_t row_data [DIM];
  ofmap_word_t col_sum [DIM];
  logic [DIM-1:0] col_vld;
  logic [$clog2(`CONV_FIFO_DEPTH+1)-1:0] free_slots;

  spad_bus_if if_bus ();
  spad_bus_if wt_bus ();
  spad_bus_if fd_bus ();

  scratchpad u_scratchpad (
    .clk(clk), .rst_n(rst_n),
    .if_bus(if_bus), .wt_bus(wt_bus), .fd_bus(fd_bus)
  );

  tile_loader #(.BASE(`CONV_IFMAP_BASE), .WORDS(`CONV_PIXELS * DIM)) ifmap_loader (
    .clk(clk), .rst_n(rst_n),
    .dat(ifmap_dat), .vld(ifmap_vld), .rdy(ifmap_rdy),
    .bus(if_bus), .tile_full(ifmap_full), .tile_release(tile_release)
  );

  tile_loader #(.BASE(`CONV_WEIGHT_BASE), .WORDS(DIM * DIM)) weight_loader (
    .clk(clk), .rst_n(rst_n),
    .dat(weights_dat), .vld(weights_vld), .rdy(weights_rdy),
    .bus(wt_bus), .tile_full(weights_full), .tile_release(tile_release)
  );

  array_feeder u_feeder (
    .clk(clk), .rst_n(rst_n), .bus(fd_bus),
    .weights_full(weights_full), .ifmap_full(ifmap_full), .tile_release(tile_release),
    .weight_load(weight_load), .weight_row(weight_row),
    .row_vld(row_vld), .row_data(row_data), .free_slots(free_slots)
  );

  systolic_array u_array (
    .clk(clk), .rst_n(rst_n),
    .weight_load(weight_load), .weight_row(weight_row),
    .row_vld(row_vld), .row_data(row_data),
    .col_sum(col_sum), .col_vld(col_vld)
  );

  ofmap_drain u_drain (
    .clk(clk), .rst_n(rst_n),
    .col_sum(col_sum), .col_vld(col_vld),
    .ofmap_dat(ofmap_dat), .ofmap_vld(ofmap_vld), .ofmap_rdy(ofmap_rdy),
    .free_slots(free_slots)
  );

endmodule

`default_nettype wire

// File: src/ofmap_drain.sv
`timescale 1ns/1ns
`default_nettype none

`include "conv_defines.svh"

module ofmap_drain (
  input logic clk,
  input logic rst_n,
  input conv_pkg::ofmap_word_t col_sum [`CONV_ARRAY_DIM],
  input logic [`CONV_ARRAY_DIM-1:0] col_vld,
  output conv_pkg::ofmap_word_t ofmap_dat,
  output logic ofmap_vld,
  input logic ofmap_rdy,
  output logic [$clog2(`CONV_FIFO_DEPTH+1)-1:0] free_slots
);
  import conv_pkg::*;

  localparam int DIM = `CONV_ARRAY_DIM;
  localparam int DEPTH = `CONV_FIFO_DEPTH;
  localparam int PW = $clog2(DEPTH);
  localparam int FW = $clog2(DEPTH + 1);

  ofmap_word_t al_sum [DIM];
  logic [DIM-1:0] al_vld;
  ofmap_word_t mem [DEPTH];
  logic [PW-1:0] wr_q;
  logic [PW-1:0] rd_q;
  logic [FW-1:0] count_q;
  logic push;
  logic pop;

  // column c lands c cycles late, so delay it DIM-1-c
  for (genvar c = 0; c < DIM; c++) begin : g_deskew
    localparam int L = DIM - 1 - c;
    if (L == 0) begin : g_direct
      assign al_sum[c] = col_sum[c];
      assign al_vld[c] = col_vld[c];
    end else begin : g_delay
      ofmap_word_t d_q [L];
      logic [L-1:0] v_q;
      always_ff @(posedge clk) begin
        d_q[0] <= col_sum[c];
        for (int k = 1; k < L; k++) d_q[k] <= d_q[k-1];
      end
      always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) v_q <= '0;
        else v_q <= L'({v_q, col_vld[c]});
      end
      assign al_sum[c] = d_q[L-1];
      assign al_vld[c] = v_q[L-1];
    end
  end

  assign push = &al_vld;  // whole pixel at once
  assign pop = ofmap_vld && ofmap_rdy;

  always_ff @(posedge clk) begin
    if (push) begin
      for (int k = 0; k < DIM; k++) mem[wr_q + PW'(k)] <= al_sum[k];  // oc order
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_q <= '0;
      rd_q <= '0;
      count_q <= '0;
    end else begin
      if (push) wr_q <= wr_q + PW'(DIM);
      if (pop) rd_q <= rd_q + 1'b1;
      count_q <= count_q + (push ? FW'(DIM) : '0) - FW'(pop);
    end
  end

  assign ofmap_dat = mem[rd_q];
  assign ofmap_vld = (count_q != '0);
  assign free_slots = FW'(DEPTH) - count_q;

endmodule

`default_nettype wire

// File: src/systolic_array.sv
`timescale 1ns/1ns
`default_nettype none

`include "conv_defines.svh"

module systolic_array (
  input logic clk,
  input logic rst_n,
  input logic weight_load,
  input conv_pkg::weight_word_t weight_row [`CONV_ARRAY_DIM],
  input logic row_vld,
  input conv_pkg::ifmap_word_t row_data [`CONV_ARRAY_DIM],
  output conv_pkg::ofmap_word_t col_sum [`CONV_ARRAY_DIM],
  output logic [`CONV_ARRAY_DIM-1:0] col_vld
);
  import conv_pkg::*;

  localparam int DIM = `CONV_ARRAY_DIM;

  weight_word_t w_q [DIM][DIM];
  ifmap_word_t a_q [DIM][DIM-1];  // ifmap moving right
  ofmap_word_t s_q [DIM][DIM];    // partial sums moving down
  logic v_q [DIM][DIM];

  for (genvar r = 0; r < DIM; r++) begin : g_row
    for (genvar c = 0; c < DIM; c++) begin : g_col
      ifmap_word_t a_in;
      ofmap_word_t s_in;
      weight_word_t w_in;
      logic v_in;

      if (c == 0) begin : g_left
        assign a_in = row_data[r];
      end else begin : g_inner
        assign a_in = a_q[r][c-1];
      end

      if (r == 0) begin : g_top
        assign s_in = '0;  // no partial sums enter from above
        assign w_in = weight_row[c];
        if (c == 0) begin : g_corner
          assign v_in = row_vld;
        end else begin : g_edge
          assign v_in = v_q[0][c-1];  // top row carries the valid across
        end
      end else begin : g_below
        assign s_in = s_q[r-1][c];
        assign w_in = w_q[r-1][c];
        assign v_in = v_q[r-1][c];
      end

      always_ff @(posedge clk) begin
        if (weight_load) w_q[r][c] <= w_in;
        s_q[r][c] <= s_in + ofmap_word_t'(a_in) * ofmap_word_t'(w_q[r][c]);
      end

      if (c < DIM - 1) begin : g_pass
        always_ff @(posedge clk) a_q[r][c] <= a_in;
      end

      always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) v_q[r][c] <= 1'b0;
        else v_q[r][c] <= v_in;
      end
    end
  end

  for (genvar c = 0; c < DIM; c++) begin : g_out
    assign col_sum[c] = s_q[DIM-1][c];
    assign col_vld[c] = v_q[DIM-1][c];
  end

endmodule

`default_nettype wire

// File: src/array_feeder.sv
`timescale 1ns/1ns
`default_nettype none

`include "conv_defines.svh"

module array_feeder (
  input logic clk,
  input logic rst_n,
  spad_bus_if.master bus,
  input logic weights_full,
  input logic ifmap_full,
  output logic tile_release,
  output logic weight_load,
  output conv_pkg::weight_word_t weight_row [`CONV_ARRAY_DIM],
  output logic row_vld,
  output conv_pkg::ifmap_word_t row_data [`CONV_ARRAY_DIM],
  input logic [$clog2(`CONV_FIFO_DEPTH+1)-1:0] free_slots
);
  import conv_pkg::*;

  localparam int DIM = `CONV_ARRAY_DIM;
  localparam int LAT = 2 * DIM;  // launch to FIFO write, in cycles
  localparam int IW = $clog2(`CONV_PIXELS * DIM);

  feeder_state_t state_q;
  logic [IW-1:0] idx_q;
  ifmap_word_t pix_q [DIM];
  logic pix_ready_q;
  logic [LAT-1:0] launch_q;
  logic [2:0] inflight_q;
  logic bus_done;
  logic bus_free;
  logic credit_ok;
  logic go;

  assign bus_done = bus.req && bus.ack;
  assign bus_free = !bus.req && !bus.ack;
  assign credit_ok = (int'(free_slots) - DIM * int'(inflight_q)) >= DIM;
  assign go = (state_q == fd_stream) && pix_ready_q && credit_ok;
  assign tile_release = (state_q == fd_finish);
  assign row_vld = launch_q[0];
  assign bus.op = spad_read;
  assign bus.wdata = '0;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= fd_idle;
      idx_q <= '0;
      pix_ready_q <= 1'b0;
      weight_load <= 1'b0;
      bus.req <= 1'b0;
      bus.addr <= '0;
    end else begin
      weight_load <= 1'b0;
      case (state_q)
        fd_idle: if (weights_full && ifmap_full && inflight_q == '0) begin
          idx_q <= '0;
          state_q <= fd_weights;
        end
        fd_weights: begin
          // ic 3 goes in first so it ends up in the bottom row
          if (bus_free) begin
            bus.req <= 1'b1;
            bus.addr <= spad_addr_t'(`CONV_WEIGHT_BASE + {~idx_q[3:2], idx_q[1:0]});
          end
          if (bus_done) begin
            bus.req <= 1'b0;
            weight_load <= (idx_q[1:0] == 2'd3);
            idx_q <= idx_q + 1'b1;
            if (idx_q == IW'(DIM * DIM - 1)) begin
              idx_q <= '0;
              state_q <= fd_stream;
            end
          end
        end
        fd_stream: begin
          if (bus_free && !pix_ready_q) begin
            bus.req <= 1'b1;
            bus.addr <= spad_addr_t'(`CONV_IFMAP_BASE + int'(idx_q));
          end
          if (bus_done) begin
            bus.req <= 1'b0;
            idx_q <= idx_q + 1'b1;
            if (idx_q[1:0] == 2'd3) pix_ready_q <= 1'b1;
          end
          if (go) begin
            pix_ready_q <= 1'b0;
            if (idx_q == '0) state_q <= fd_finish;  // index wrapped, last pixel
          end
        end
        fd_finish: state_q <= fd_idle;
        default: state_q <= fd_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (bus_done && state_q == fd_weights) weight_row[idx_q[1:0]] <= bus.rdata;
    if (bus_done && state_q == fd_stream) pix_q[idx_q[1:0]] <= bus.rdata;
  end

  // pixels in the array or deskew, not yet in the FIFO
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      launch_q <= '0;
      inflight_q <= '0;
    end else begin
      launch_q <= {launch_q[LAT-2:0], go};
      inflight_q <= inflight_q + 3'(go) - 3'(launch_q[LAT-1]);
    end
  end

  // row r lags row 0 by r cycles
  for (genvar r = 0; r < DIM; r++) begin : g_skew
    ifmap_word_t chain_q [r+1];
    always_ff @(posedge clk) begin
      if (go) chain_q[0] <= pix_q[r];
      for (int k = 1; k <= r; k++) chain_q[k] <= chain_q[k-1];
    end
    assign row_data[r] = chain_q[r];
  end

endmodule

`default_nettype wire

// File: src/tile_loader.sv
`timescale 1ns/1ns
`default_nettype none

`include "conv_defines.svh"

module tile_loader #(
  parameter int BASE = 0,
  parameter int WORDS = 16
) (
  input logic clk,
  input logic rst_n,
  input logic [`CONV_IFMAP_W-1:0] dat,
  input logic vld,
  output logic rdy,
  spad_bus_if.master bus,
  output logic tile_full,
  input logic tile_release
);
  import conv_pkg::*;

  localparam int CW = $clog2(WORDS + 1);

  logic [CW-1:0] cnt_q;  // words stored so far
  logic busy_q;

  assign tile_full = (cnt_q == CW'(WORDS));
  assign bus.op = spad_write;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdy <= 1'b1;
      busy_q <= 1'b0;
      cnt_q <= '0;
      bus.req <= 1'b0;
      bus.addr <= '0;
    end else if (tile_release) begin
      cnt_q <= '0;
      rdy <= 1'b1;
    end else if (vld && rdy) begin
      bus.req <= 1'b1;
      bus.addr <= spad_addr_t'(BASE + int'(cnt_q));
      rdy <= 1'b0;
      busy_q <= 1'b1;
    end else if (bus.req && bus.ack) begin
      bus.req <= 1'b0;
    end else if (busy_q && !bus.req && !bus.ack) begin
      // word stored once ack has fallen
      busy_q <= 1'b0;
      cnt_q <= cnt_q + 1'b1;
      rdy <= (cnt_q != CW'(WORDS - 1));
    end
  end

  always_ff @(posedge clk) begin
    if (vld && rdy) bus.wdata <= dat;
  end

endmodule

`default_nettype wire

// File: src/scratchpad.sv
`timescale 1ns/1ns
`default_nettype none

`include "conv_defines.svh"

module scratchpad (
  input logic clk,
  input logic rst_n,
  spad_bus_if.slave if_bus,
  spad_bus_if.slave wt_bus,
  spad_bus_if.slave fd_bus
);
  import conv_pkg::*;

  localparam int NPORT = 3;

  typedef enum logic [1:0] {
    sp_idle,
    sp_access,
    sp_ack
  } grant_state_t;

  grant_state_t state_q;
  logic [1:0] gnt_q;  // also the round-robin pointer
  logic [1:0] pick;
  logic any_req;
  logic [NPORT-1:0] req_vec;
  spad_op_t op_vec [NPORT];
  spad_addr_t addr_vec [NPORT];
  logic [`CONV_IFMAP_W-1:0] wdata_vec [NPORT];
  logic [`CONV_IFMAP_W-1:0] mem [`CONV_SPAD_DEPTH];
  logic [`CONV_IFMAP_W-1:0] rdata_q;

  assign req_vec = {fd_bus.req, wt_bus.req, if_bus.req};
  assign op_vec[0] = if_bus.op;
  assign op_vec[1] = wt_bus.op;
  assign op_vec[2] = fd_bus.op;
  assign addr_vec[0] = if_bus.addr;
  assign addr_vec[1] = wt_bus.addr;
  assign addr_vec[2] = fd_bus.addr;
  assign wdata_vec[0] = if_bus.wdata;
  assign wdata_vec[1] = wt_bus.wdata;
  assign wdata_vec[2] = fd_bus.wdata;

  // first pending port after the last grant
  always_comb begin
    int idx;
    pick = gnt_q;
    any_req = 1'b0;
    for (int k = 1; k <= NPORT; k++) begin
      idx = (int'(gnt_q) + k) % NPORT;
      if (!any_req && req_vec[idx]) begin
        pick = 2'(idx);
        any_req = 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= sp_idle;
      gnt_q <= 2'd2;  // port 0 wins first
    end else begin
      case (state_q)
        sp_idle: if (any_req) begin
          gnt_q <= pick;
          state_q <= sp_access;
        end
        sp_access: state_q <= sp_ack;
        sp_ack: if (!req_vec[gnt_q]) state_q <= sp_idle;  // hold grant through ack fall
        default: state_q <= sp_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == sp_access) begin
      if (op_vec[gnt_q] == spad_write) mem[addr_vec[gnt_q]] <= wdata_vec[gnt_q];
      rdata_q <= mem[addr_vec[gnt_q]];
    end
  end

  assign if_bus.ack = (state_q == sp_ack) && (gnt_q == 2'd0);
  assign wt_bus.ack = (state_q == sp_ack) && (gnt_q == 2'd1);
  assign fd_bus.ack = (state_q == sp_ack) && (gnt_q == 2'd2);
  assign if_bus.rdata = rdata_q;
  assign wt_bus.rdata = rdata_q;
  assign fd_bus.rdata = rdata_q;

endmodule

`default_nettype wire

// File: src/spad_bus_if.sv
`timescale 1ns/1ns
`default_nettype none

`include "conv_defines.svh"

interface spad_bus_if;
  import conv_pkg::*;

  logic req;
  logic ack;
  spad_op_t op;
  spad_addr_t addr;
  logic [`CONV_IFMAP_W-1:0] wdata;
  logic [`CONV_IFMAP_W-1:0] rdata;  // valid while ack high

  modport master (output req, op, addr, wdata, input ack, rdata);
  modport slave (input req, op, addr, wdata, output ack, rdata);

endinterface

`default_nettype wire

// File: src/conv_pkg.sv
`default_nettype none

`include "conv_defines.svh"

package conv_pkg;

  typedef logic [`CONV_IFMAP_W-1:0]  ifmap_word_t;
  typedef logic [`CONV_WEIGHT_W-1:0] weight_word_t;
  typedef logic [`CONV_OFMAP_W-1:0]  ofmap_word_t;
  typedef logic [`CONV_SPAD_AW-1:0]  spad_addr_t;

  typedef enum logic {
    spad_read,
    spad_write
  } spad_op_t;

  typedef enum logic [1:0] {
    fd_idle,
    fd_weights,  // weight rows into the array
    fd_stream,   // pixels through the skew
    fd_finish
  } feeder_state_t;

endpackage

`default_nettype wire

// File: src/conv_defines.svh
`ifndef CONV_DEFINES_SVH
`define CONV_DEFINES_SVH

// array geometry and job size
`define CONV_ARRAY_DIM   4
`define CONV_PIXELS      8

// word widths
`define CONV_IFMAP_W     16
`define CONV_WEIGHT_W    16
`define CONV_OFMAP_W     32

// scratchpad layout, weights first then ifmap
`define CONV_WEIGHT_BASE 0
`define CONV_IFMAP_BASE  16
`define CONV_SPAD_DEPTH  48
`define CONV_SPAD_AW     6

`define CONV_FIFO_DEPTH  8

`endif
